// File: filelist.f
+incdir+.
csr_addr_pkg.sv
csr_ctl_pkg.sv
csr_alu.sv
reg_csr.sv
trap_ctrl.sv
csr_unit.sv
tb_csr_unit.sv

// File: tb_csr_unit.sv
/*
 * testbench for csr_unit: shadow CSR model, LFSR stimulus,
 * compare process on rd_data_o, mstatus_o, mie_o and the redirect
 */
`include "csr_macros.svh"

module tb_csr_unit;

	import csr_addr_pkg::*;
	import csr_ctl_pkg::*;

	localparam int K_CSR    = 0;
	localparam int K_TRAP   = 1;
	localparam int K_MRET   = 2;
	localparam int K_RETIRE = 3;

	logic		clk;
	logic		rst_i;
	logic		csr_valid_i;
	csr_op_e	csr_op_i;
	csr_addr_t	csr_addr_i;
	logic [4:0]	rs1_idx_i;
	csr_data_t	rs1_data_i;
	logic		retire_i;
	logic		trap_i;
	csr_data_t	trap_cause_i;
	csr_data_t	trap_pc_i;
	csr_data_t	trap_tval_i;
	logic		mret_i;
	csr_data_t	rd_data_o;
	csr_data_t	mstatus_o;
	csr_data_t	mie_o;
	logic		busy_o;
	logic		redirect_valid_o;
	csr_data_t	redirect_pc_o;

	// reference state
	csr_data_t	shadow [12];
	csr_data_t	mcyc_base;
	csr_data_t	edge_cnt;
	logic [31:0]	lfsr;

	// expectations handed to the compare process
	logic		chk_rd;
	logic		chk_lvl;
	logic		redir_armed;
	csr_data_t	exp_rd;
	csr_data_t	exp_mst;
	csr_data_t	exp_mie;
	csr_data_t	exp_redir;
	int		redir_cnt;
	int		errors;
	int		tests_run;
	int		tests_failed;

	csr_addr_e	addr_list [12] = '{CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
		CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP, CSR_MHARTID, CSR_MCYCLE, CSR_MINSTRET};
	csr_op_e	op_list [6] = '{RW, RS, RC, RWI, RSI, RCI};

	csr_unit csr_unit_i (.*);

	always #20 clk = ~clk;

	// edge count since reset release matches mcycle while never written
	always @(posedge clk) begin
		if (rst_i) begin
			edge_cnt <= '0;
		end else begin
			edge_cnt <= edge_cnt + 1'b1;
		end
	end

	function automatic void lfsr_step();
		if (lfsr[0]) begin
			lfsr = (lfsr >> 1) ^ 32'h8020_0003;
		end else begin
			lfsr = lfsr >> 1;
		end
	endfunction

	function automatic csr_data_t rand_bits(input int n);
		csr_data_t r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_step();
			r = {r[`CSR_XLEN-2:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic int csr_slot(input csr_addr_t a);
		for (int i = 0; i < 12; i++) begin
			if (addr_list[i] == a) begin
				return i;
			end
		end
		return -1;
	endfunction

	function automatic csr_data_t model_read(input csr_addr_t a);
		if (a == CSR_MCYCLE) begin
			return mcyc_base + edge_cnt;
		end
		if (csr_slot(a) < 0) begin
			return '0;
		end
		return shadow[csr_slot(a)];
	endfunction

	// one architectural step of the reference model
	function automatic void csr_model_step(input int kind, input csr_op_e op, input csr_addr_t a,
		input logic [4:0] idx, input csr_data_t d0, input csr_data_t d1, input csr_data_t d2);
		csr_data_t	old;
		csr_data_t	src;
		csr_data_t	nv;
		csr_data_t	st;
		logic		wr;
		st = shadow[csr_slot(CSR_MSTATUS)];
		case (kind)
			K_CSR: begin
				old = model_read(a);
				src = (op == RWI || op == RSI || op == RCI) ? {{(`CSR_XLEN-5){1'b0}}, idx} : d0;
				wr = 1'b1;
				nv = src;
				if (op == RS || op == RSI) begin
					wr = (idx != 0);
					nv = old | src;
				end
				if (op == RC || op == RCI) begin
					wr = (idx != 0);
					nv = old & ~src;
				end
				// loaded at the coming edge and counting resumes after it
				if (wr && a == CSR_MCYCLE) begin
					mcyc_base = nv - (edge_cnt + 1);
				end else if (wr && csr_slot(a) >= 0) begin
					shadow[csr_slot(a)] = nv;
				end
			end
			K_TRAP: begin
				shadow[csr_slot(CSR_MCAUSE)] = d0;
				shadow[csr_slot(CSR_MEPC)] = d1;
				shadow[csr_slot(CSR_MTVAL)] = d2;
				st[`CSR_MSTATUS_MPIE_BIT] = st[`CSR_MSTATUS_MIE_BIT];
				st[`CSR_MSTATUS_MIE_BIT] = 1'b0;
				shadow[csr_slot(CSR_MSTATUS)] = st;
			end
			K_MRET: begin
				st[`CSR_MSTATUS_MIE_BIT] = st[`CSR_MSTATUS_MPIE_BIT];
				st[`CSR_MSTATUS_MPIE_BIT] = 1'b1;
				shadow[csr_slot(CSR_MSTATUS)] = st;
			end
			default: shadow[csr_slot(CSR_MINSTRET)] += 1;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input csr_data_t got, input csr_data_t exp);
		$display("MISMATCH %s: got %h expected %h (addr %h)", name, got, exp, csr_addr_i);
		errors++;
	endtask

	// outputs still hold the pre-edge state here
	always @(posedge clk) begin
		if (chk_rd && rd_data_o !== exp_rd) report_mismatch("rd_data_o", rd_data_o, exp_rd);
		if (chk_lvl && mstatus_o !== exp_mst) report_mismatch("mstatus_o", mstatus_o, exp_mst);
		if (chk_lvl && mie_o !== exp_mie) report_mismatch("mie_o", mie_o, exp_mie);
		if (redirect_valid_o === 1'b1) begin
			if (!redir_armed) begin
				$display("ERROR: redirect_valid_o pulsed with no trap or mret pending");
				errors++;
			end else if (redirect_pc_o !== exp_redir) begin
				report_mismatch("redirect_pc_o", redirect_pc_o, exp_redir);
			end
			redir_armed = 1'b0;
			redir_cnt++;
		end
	end

	task automatic next_cycle(input logic rd_on, input logic lvl_on);
		@(negedge clk);
		csr_valid_i = 1'b0;
		retire_i = 1'b0;
		trap_i = 1'b0;
		mret_i = 1'b0;
		chk_rd = rd_on;
		chk_lvl = lvl_on;
		exp_mst = shadow[csr_slot(CSR_MSTATUS)];
		exp_mie = shadow[csr_slot(CSR_MIE)];
	endtask

	task automatic drive_read(input csr_addr_t a);
		next_cycle(1'b1, 1'b1);
		csr_addr_i = a;
		exp_rd = model_read(a);
	endtask

	task automatic drive_csr(input csr_op_e op, input csr_addr_t a, input logic [4:0] idx,
		input csr_data_t d);
		drive_read(a);
		csr_valid_i = 1'b1;
		csr_op_i = op;
		rs1_idx_i = idx;
		rs1_data_i = d;
		csr_model_step(K_CSR, op, a, idx, d, '0, '0);
	endtask

	task automatic wait_redirect(input int cnt0);
		int n;
		n = 0;
		while (redir_cnt == cnt0 && n < 20) begin
			next_cycle(1'b0, 1'b0);
			n++;
		end
		if (redir_cnt == cnt0) begin
			$display("ERROR: timeout waiting for redirect_valid_o");
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err0);
		next_cycle(1'b0, 1'b0);
		tests_run++;
		if (errors != err0) begin
			tests_failed++;
			$display("test %-12s FAIL (%0d errors)", name, errors - err0);
		end else begin
			$display("test %-12s ok", name);
		end
	endtask

	initial begin
		int		err0;
		int		cnt0;
		int		n;
		csr_addr_t	a;
		clk = 1'b0;
		rst_i = 1'b1;
		{csr_valid_i, retire_i, trap_i, mret_i} = '0;
		csr_op_i = RW;
		csr_addr_i = '0;
		rs1_idx_i = '0;
		rs1_data_i = '0;
		{trap_cause_i, trap_pc_i, trap_tval_i} = '0;
		{chk_rd, chk_lvl, redir_armed} = '0;
		{exp_rd, exp_mst, exp_mie, exp_redir} = '0;
		{redir_cnt, errors, tests_run, tests_failed} = '0;
		lfsr = 32'h34d5_8865;
		foreach (shadow[i]) shadow[i] = '0;
		shadow[csr_slot(CSR_MSTATUS)] = `CSR_MSTATUS_RESET;
		shadow[csr_slot(CSR_MISA)] = `CSR_MISA_RESET;
		shadow[csr_slot(CSR_MIE)] = `CSR_MIE_RESET;
		shadow[csr_slot(CSR_MTVEC)] = `CSR_MTVEC_RESET;
		mcyc_base = '0;
		repeat (5) @(negedge clk);
		rst_i = 1'b0;

		err0 = errors;
		foreach (addr_list[i]) drive_read(addr_list[i]);
		drive_read(12'h7c0);
		end_test("reset", err0);

		// counters stay out of the random mix
		err0 = errors;
		repeat (200) begin
			a = addr_list[rand_bits(4) % 10];
			drive_csr(op_list[rand_bits(3) % 6], a, 5'(rand_bits(5)), rand_bits(64));
			drive_read(a);
		end
		end_test("random", err0);

		err0 = errors;
		drive_csr(RW, CSR_MSCRATCH, 5'd9, 64'h5a5a_0f0f_3c3c_9696);
		drive_csr(RS, CSR_MSCRATCH, 5'd0, '1);
		drive_csr(RC, CSR_MSCRATCH, 5'd0, '1);
		drive_csr(RSI, CSR_MSCRATCH, 5'd0, '1);
		drive_csr(RCI, CSR_MSCRATCH, 5'd0, '1);
		drive_csr(RW, CSR_MSCRATCH, 5'd0, 64'h0123_4567_89ab_cdef);
		drive_read(CSR_MSCRATCH);
		end_test("zero index", err0);

		err0 = errors;
		drive_csr(RW, CSR_MCYCLE, 5'd1, rand_bits(64));
		n = int'(rand_bits(4)) + 1;
		repeat (n) next_cycle(1'b0, 1'b1);
		drive_read(CSR_MCYCLE);
		n = int'(rand_bits(4)) + 1;
		repeat (n) begin
			next_cycle(1'b0, 1'b1);
			retire_i = 1'b1;
			csr_model_step(K_RETIRE, RW, '0, '0, '0, '0, '0);
		end
		drive_read(CSR_MINSTRET);
		end_test("counters", err0);

		err0 = errors;
		cnt0 = redir_cnt;
		next_cycle(1'b0, 1'b0);
		trap_i = 1'b1;
		trap_cause_i = rand_bits(64);
		trap_pc_i = rand_bits(64);
		trap_tval_i = rand_bits(64);
		exp_redir = shadow[csr_slot(CSR_MTVEC)] & ~64'h3;
		redir_armed = 1'b1;
		csr_model_step(K_TRAP, RW, '0, '0, trap_cause_i, trap_pc_i, trap_tval_i);
		wait_redirect(cnt0);
		drive_read(CSR_MEPC);
		drive_read(CSR_MCAUSE);
		drive_read(CSR_MTVAL);
		drive_read(CSR_MSTATUS);
		end_test("trap", err0);

		err0 = errors;
		cnt0 = redir_cnt;
		next_cycle(1'b0, 1'b0);
		mret_i = 1'b1;
		exp_redir = shadow[csr_slot(CSR_MEPC)];
		redir_armed = 1'b1;
		csr_model_step(K_MRET, RW, '0, '0, '0, '0, '0);
		next_cycle(1'b0, 1'b0);
		if (busy_o !== 1'b1) begin
			report_mismatch("busy_o", busy_o, 64'h1);
		end
		// must be ignored while busy
		trap_i = 1'b1;
		trap_pc_i = rand_bits(64);
		wait_redirect(cnt0);
		repeat (8) next_cycle(1'b0, 1'b1);
		if (redir_cnt != cnt0 + 1) begin
			$display("ERROR: trap_i taken while busy_o was high");
			errors++;
		end
		if (busy_o !== 1'b0) begin
			report_mismatch("busy_o", busy_o, 64'h0);
		end
		drive_read(CSR_MSTATUS);
		end_test("mret", err0);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: csr_unit.sv
/*
 * machine CSR unit top: csr_alu, reg_csr and trap_ctrl
 */
module csr_unit (
	input	logic						clk,
	input	logic						rst_i,
	input	logic						csr_valid_i,
	input	csr_ctl_pkg::csr_op_e		csr_op_i,
	input	csr_addr_pkg::csr_addr_t	csr_addr_i,
	input	logic	[4:0]				rs1_idx_i,
	input	csr_ctl_pkg::csr_data_t		rs1_data_i,
	input	logic						retire_i,
	input	logic						trap_i,
	input	csr_ctl_pkg::csr_data_t		trap_cause_i,
	input	csr_ctl_pkg::csr_data_t		trap_pc_i,
	input	csr_ctl_pkg::csr_data_t		trap_tval_i,
	input	logic						mret_i,
	output	csr_ctl_pkg::csr_data_t		rd_data_o,
	output	csr_ctl_pkg::csr_data_t		mstatus_o,
	output	csr_ctl_pkg::csr_data_t		mie_o,
	output	logic						busy_o,
	output	logic						redirect_valid_o,
	output	csr_ctl_pkg::csr_data_t		redirect_pc_o
);

	import csr_addr_pkg::*;
	import csr_ctl_pkg::*;

	logic		ex_we;
	csr_data_t	ex_data;
	logic		clt_we;
	csr_addr_t	clt_addr;
	csr_data_t	clt_data;
	csr_data_t	mtvec;
	csr_data_t	mepc;

	// old value feeds the alu in the same cycle
	csr_alu csr_alu_i (
		.csr_valid_i	(csr_valid_i),
		.csr_op_i		(csr_op_i),
		.rs1_idx_i		(rs1_idx_i),
		.rs1_data_i		(rs1_data_i),
		.old_data_i		(rd_data_o),
		.we_o			(ex_we),
		.wdata_o		(ex_data)
	);

	reg_csr reg_csr_i (
		.clk			(clk),
		.rst_i			(rst_i),
		.retire_i		(retire_i),
		.ex_we_i		(ex_we),
		.ex_addr_i		(csr_addr_i),
		.ex_data_i		(ex_data),
		.clt_we_i		(clt_we),
		.clt_addr_i		(clt_addr),
		.clt_data_i		(clt_data),
		.raddr_i		(csr_addr_i),
		.rdata_o		(rd_data_o),
		.mstatus_o		(mstatus_o),
		.mie_o			(mie_o),
		.mtvec_o		(mtvec),
		.mepc_o			(mepc)
	);

	trap_ctrl trap_ctrl_i (
		.clk				(clk),
		.rst_i				(rst_i),
		.trap_i				(trap_i),
		.trap_cause_i		(trap_cause_i),
		.trap_pc_i			(trap_pc_i),
		.trap_tval_i		(trap_tval_i),
		.mret_i				(mret_i),
		.mstatus_i			(mstatus_o),
		.mtvec_i			(mtvec),
		.mepc_i				(mepc),
		.clt_we_o			(clt_we),
		.clt_addr_o			(clt_addr),
		.clt_data_o			(clt_data),
		.busy_o				(busy_o),
		.redirect_valid_o	(redirect_valid_o),
		.redirect_pc_o		(redirect_pc_o)
	);

endmodule

// File: trap_ctrl.sv
/*
 * trap and mret sequencer: control port CSR writes and fetch redirect
 */
`include "csr_macros.svh"

module trap_ctrl (
	input	logic						clk,
	input	logic						rst_i,
	input	logic						trap_i,
	input	csr_ctl_pkg::csr_data_t		trap_cause_i,
	input	csr_ctl_pkg::csr_data_t		trap_pc_i,
	input	csr_ctl_pkg::csr_data_t		trap_tval_i,
	input	logic						mret_i,
	input	csr_ctl_pkg::csr_data_t		mstatus_i,
	input	csr_ctl_pkg::csr_data_t		mtvec_i,
	input	csr_ctl_pkg::csr_data_t		mepc_i,
	output	logic						clt_we_o,
	output	csr_addr_pkg::csr_addr_t	clt_addr_o,
	output	csr_ctl_pkg::csr_data_t		clt_data_o,
	output	logic						busy_o,
	output	logic						redirect_valid_o,
	output	csr_ctl_pkg::csr_data_t		redirect_pc_o
);

	import csr_addr_pkg::*;
	import csr_ctl_pkg::*;

	trap_state_e	state_q;
	trap_state_e	state_d;
	logic			mret_q;
	logic			accept;
	csr_data_t		pc_q;
	csr_data_t		cause_q;
	csr_data_t		tval_q;
	csr_data_t		mstatus_nxt;

	// requests only taken when idle, trap over mret
	assign accept = (state_q == IDLE) & (trap_i | mret_i);

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (trap_i) begin
					state_d = W_MEPC;
				end else if (mret_i) begin
					state_d = W_MSTATUS;
				end
			end
			W_MEPC:    state_d = W_MCAUSE;
			W_MCAUSE:  state_d = W_MTVAL;
			W_MTVAL:   state_d = W_MSTATUS;
			W_MSTATUS: state_d = REDIRECT;
			REDIRECT:  state_d = IDLE;
			default:   state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= IDLE;
			mret_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			if (accept) begin
				mret_q <= ~trap_i;
			end
		end
	end

	// exception payload
	always_ff @(posedge clk) begin
		if (accept && trap_i) begin
			pc_q    <= trap_pc_i;
			cause_q <= trap_cause_i;
			tval_q  <= trap_tval_i;
		end
	end

	// interrupt enable stack push on trap, pop on mret
	always_comb begin
		mstatus_nxt = mstatus_i;
		if (mret_q) begin
			mstatus_nxt[`CSR_MSTATUS_MIE_BIT]  = mstatus_i[`CSR_MSTATUS_MPIE_BIT];
			mstatus_nxt[`CSR_MSTATUS_MPIE_BIT] = 1'b1;
		end else begin
			mstatus_nxt[`CSR_MSTATUS_MPIE_BIT] = mstatus_i[`CSR_MSTATUS_MIE_BIT];
			mstatus_nxt[`CSR_MSTATUS_MIE_BIT]  = 1'b0;
		end
	end

	// one control write per state
	always_comb begin
		clt_we_o   = 1'b1;
		clt_addr_o = '0;
		clt_data_o = '0;
		case (state_q)
			W_MEPC: begin
				clt_addr_o = CSR_MEPC;
				clt_data_o = pc_q;
			end
			W_MCAUSE: begin
				clt_addr_o = CSR_MCAUSE;
				clt_data_o = cause_q;
			end
			W_MTVAL: begin
				clt_addr_o = CSR_MTVAL;
				clt_data_o = tval_q;
			end
			W_MSTATUS: begin
				clt_addr_o = CSR_MSTATUS;
				clt_data_o = mstatus_nxt;
			end
			default: clt_we_o = 1'b0;
		endcase
	end

	assign busy_o           = (state_q != IDLE);
	assign redirect_valid_o = (state_q == REDIRECT);
	// direct mode only, mode bits masked off
	assign redirect_pc_o    = mret_q ? mepc_i : {mtvec_i[`CSR_XLEN-1:2], 2'b00};

endmodule

// File: reg_csr.sv
/*
 * machine CSR storage, merged execute/control write port,
 * mcycle and minstret counters, combinational read mux
 */
`include "csr_macros.svh"

module reg_csr (
	input	logic						clk,
	input	logic						rst_i,
	input	logic						retire_i,

	input	logic						ex_we_i,
	input	csr_addr_pkg::csr_addr_t	ex_addr_i,
	input	csr_ctl_pkg::csr_data_t		ex_data_i,

	input	logic						clt_we_i,
	input	csr_addr_pkg::csr_addr_t	clt_addr_i,
	input	csr_ctl_pkg::csr_data_t		clt_data_i,

	input	csr_addr_pkg::csr_addr_t	raddr_i,
	output	csr_ctl_pkg::csr_data_t		rdata_o,

	output	csr_ctl_pkg::csr_data_t		mstatus_o,
	output	csr_ctl_pkg::csr_data_t		mie_o,
	output	csr_ctl_pkg::csr_data_t		mtvec_o,
	output	csr_ctl_pkg::csr_data_t		mepc_o
);

	import csr_addr_pkg::*;
	import csr_ctl_pkg::*;

	logic		wr_en;
	csr_addr_t	wr_addr;
	csr_data_t	wr_data;

	csr_data_t	csr_mstatus;
	csr_data_t	csr_misa;
	csr_data_t	csr_mie;
	csr_data_t	csr_mtvec;
	csr_data_t	csr_mscratch;
	csr_data_t	csr_mepc;
	csr_data_t	csr_mcause;
	csr_data_t	csr_mtval;
	csr_data_t	csr_mip;
	csr_data_t	csr_mcycle;
	csr_data_t	csr_minstret;
	csr_data_t	csr_mhartid;

	// execute port wins, a simultaneous control write is dropped
	assign wr_en   = ex_we_i | clt_we_i;
	assign wr_addr = ex_we_i ? ex_addr_i : clt_addr_i;
	assign wr_data = ex_we_i ? ex_data_i : clt_data_i;

	// plain CSRs
	always_ff @(posedge clk) begin
		if (rst_i) begin
			csr_mstatus  <= `CSR_MSTATUS_RESET;
			csr_misa     <= `CSR_MISA_RESET;
			csr_mie      <= `CSR_MIE_RESET;
			csr_mtvec    <= `CSR_MTVEC_RESET;
			csr_mscratch <= '0;
			csr_mepc     <= '0;
			csr_mcause   <= '0;
			csr_mtval    <= '0;
			csr_mip      <= '0;
			csr_mhartid  <= '0;
		end else if (wr_en) begin
			case (wr_addr)
				CSR_MSTATUS:  csr_mstatus  <= wr_data;
				CSR_MISA:     csr_misa     <= wr_data;
				CSR_MIE:      csr_mie      <= wr_data;
				CSR_MTVEC:    csr_mtvec    <= wr_data;
				CSR_MSCRATCH: csr_mscratch <= wr_data;
				CSR_MEPC:     csr_mepc     <= wr_data;
				CSR_MCAUSE:   csr_mcause   <= wr_data;
				CSR_MTVAL:    csr_mtval    <= wr_data;
				CSR_MIP:      csr_mip      <= wr_data;
				CSR_MHARTID:  csr_mhartid  <= wr_data;
				// counters and unknown addresses handled elsewhere or dropped
				default: ;
			endcase
		end
	end

	// free running cycle counter, a write loads instead of counting
	always_ff @(posedge clk) begin
		if (rst_i) begin
			csr_mcycle <= '0;
		end else if (wr_en && wr_addr == CSR_MCYCLE) begin
			csr_mcycle <= wr_data;
		end else begin
			csr_mcycle <= csr_mcycle + 1'b1;
		end
	end

	// retirement counter
	always_ff @(posedge clk) begin
		if (rst_i) begin
			csr_minstret <= '0;
		end else if (wr_en && wr_addr == CSR_MINSTRET) begin
			csr_minstret <= wr_data;
		end else if (retire_i) begin
			csr_minstret <= csr_minstret + 1'b1;
		end
	end

	// read port, zero for anything not implemented
	always_comb begin
		case (raddr_i)
			CSR_MSTATUS:  rdata_o = csr_mstatus;
			CSR_MISA:     rdata_o = csr_misa;
			CSR_MIE:      rdata_o = csr_mie;
			CSR_MTVEC:    rdata_o = csr_mtvec;
			CSR_MSCRATCH: rdata_o = csr_mscratch;
			CSR_MEPC:     rdata_o = csr_mepc;
			CSR_MCAUSE:   rdata_o = csr_mcause;
			CSR_MTVAL:    rdata_o = csr_mtval;
			CSR_MIP:      rdata_o = csr_mip;
			CSR_MCYCLE:   rdata_o = csr_mcycle;
			CSR_MINSTRET: rdata_o = csr_minstret;
			CSR_MHARTID:  rdata_o = csr_mhartid;
			default:      rdata_o = '0;
		endcase
	end

	// levels for the trap controller and the pipeline
	assign mstatus_o = csr_mstatus;
	assign mie_o     = csr_mie;
	assign mtvec_o   = csr_mtvec;
	assign mepc_o    = csr_mepc;

endmodule

// File: csr_alu.sv
/*
 * CSR write value and write enable for CSRRW/CSRRS/CSRRC and immediate forms
 */
`include "csr_macros.svh"

module csr_alu (
	input	logic					csr_valid_i,
	input	csr_ctl_pkg::csr_op_e	csr_op_i,
	input	logic	[4:0]			rs1_idx_i,
	input	csr_ctl_pkg::csr_data_t	rs1_data_i,
	input	csr_ctl_pkg::csr_data_t	old_data_i,
	output	logic					we_o,
	output	csr_ctl_pkg::csr_data_t	wdata_o
);

	import csr_ctl_pkg::*;

	csr_data_t	src;
	csr_data_t	imm_ext;
	logic		src_nz;
	logic		op_we;

	// uimm field is rs1 index, zero extended
	assign imm_ext = {{(`CSR_XLEN-5){1'b0}}, rs1_idx_i};
	assign src = csr_op_i[2] ? imm_ext : rs1_data_i;

	// set/clear with x0 or uimm 0 is a pure read
	assign src_nz = |rs1_idx_i;

	always_comb begin
		op_we   = 1'b0;
		wdata_o = old_data_i;
		case (csr_op_i)
			RW, RWI: begin
				op_we   = 1'b1;
				wdata_o = src;
			end
			RS, RSI: begin
				op_we   = src_nz;
				wdata_o = old_data_i | src;
			end
			RC, RCI: begin
				op_we   = src_nz;
				wdata_o = old_data_i & ~src;
			end
			default: begin
				// reserved funct3, no write
				op_we   = 1'b0;
				wdata_o = old_data_i;
			end
		endcase
	end

	assign we_o = csr_valid_i & op_we;

endmodule

// File: csr_ctl_pkg.sv
/*
 * CSR data word, CSR operation encoding and trap controller states
 */
`include "csr_macros.svh"

package csr_ctl_pkg;

	// one machine word
	typedef logic [`CSR_XLEN-1:0] csr_data_t;

	// funct3 of the SYSTEM opcode
	// bit 2 selects the zero-extended immediate as source
	typedef enum logic [2:0] {
		RW	= 3'b001,
		RS	= 3'b010,
		RC	= 3'b011,
		RWI	= 3'b101,
		RSI	= 3'b110,
		RCI	= 3'b111
	} csr_op_e;

	// trap controller sequence
	// one control port write per W_* state
	typedef enum logic [2:0] {
		IDLE		= 3'd0,
		W_MEPC		= 3'd1,
		W_MCAUSE	= 3'd2,
		W_MTVAL		= 3'd3,
		W_MSTATUS	= 3'd4,
		REDIRECT	= 3'd5
	} trap_state_e;

endpackage

// File: csr_addr_pkg.sv
/*
 * CSR address type and the machine CSR address map
 */
package csr_addr_pkg;

	// 12-bit CSR address from the instruction immediate
	typedef logic [11:0] csr_addr_t;

	// machine mode CSRs implemented by reg_csr
	typedef enum csr_addr_t {
		// machine information and status
		CSR_MSTATUS		= 12'h300,
		CSR_MISA		= 12'h301,
		CSR_MIE			= 12'h304,
		CSR_MTVEC		= 12'h305,

		// trap handling
		CSR_MSCRATCH	= 12'h340,
		CSR_MEPC		= 12'h341,
		CSR_MCAUSE		= 12'h342,
		CSR_MTVAL		= 12'h343,
		CSR_MIP			= 12'h344,

		// counters
		CSR_MCYCLE		= 12'hb00,
		CSR_MINSTRET	= 12'hb02,

		// hart id is writable like every other listed CSR
		CSR_MHARTID		= 12'hf14
	} csr_addr_e;

endpackage

// File: csr_macros.svh
/*
 * data width, CSR reset values and mstatus bit positions
 */
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// machine word width
`define CSR_XLEN				64

// mstatus interrupt enable bits
`define CSR_MSTATUS_MIE_BIT		3
`define CSR_MSTATUS_MPIE_BIT	7

// mstatus comes up with MIE set, MPIE and MPP clear
`define CSR_MSTATUS_RESET		64'h0000_0000_0000_0008

// MEIE, MTIE and MSIE all enabled
`define CSR_MIE_RESET			64'h0000_0000_0000_0888

// MXL = 2 (64 bit), extension I only
`define CSR_MISA_RESET			64'h8000_0000_0000_0100

// direct mode trap handler base
`define CSR_MTVEC_RESET			64'h0000_0000_0000_0200

`endif
